// ==== hdl/fetchPkg.sv ====
package fetchPkg;

    ////////////////////////////////////////////////////////////////////////////
    // Datapath widths
    ////////////////////////////////////////////////////////////////////////////
    localparam int addrWidth  = 32;
    localparam int instrWidth = 32;

    // First fetch address out of reset
    localparam logic [addrWidth-1:0] resetPc = '0;

    ////////////////////////////////////////////////////////////////////////////
    // Fetch structs
    ////////////////////////////////////////////////////////////////////////////

    // Redirect from execute
    typedef struct packed {
        logic                 valid;
        logic [addrWidth-1:0] target;
    } redirect_t;

    // Combinational answer of the instruction cache
    typedef struct packed {
        logic                  hit;
        logic [instrWidth-1:0] instr;
    } imemResp_t;

    // Item formed by the memory port on a hit
    typedef struct packed {
        logic                  valid;
        logic [addrWidth-1:0]  addr;
        logic [instrWidth-1:0] instr;
    } fetched_t;

    // IF/ID payload, 100 bits
    typedef struct packed {
        logic                  valid;
        logic [addrWidth-1:0]  addr;
        logic [instrWidth-1:0] instr;
        logic [addrWidth-1:0]  predictedNext;
        logic                  predTaken;
        logic [1:0]            counter;
    } ifIdEntry_t;

endpackage

// ==== hdl/predictPkg.sv ====
package predictPkg;

    import fetchPkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Table geometry
    ////////////////////////////////////////////////////////////////////////////
    localparam int predEntries    = 16;
    // Index is pc[5:2], tag is pc[31:6]
    localparam int predIndexWidth = 4;
    localparam int tagWidth       = addrWidth - predIndexWidth - 2;

    // 2-bit saturating counter, msb set means taken
    typedef enum logic [1:0] {
        strongNotTaken = 2'b00,
        weakNotTaken   = 2'b01,
        weakTaken      = 2'b10,
        strongTaken    = 2'b11
    } counter_t;

    // Resolved branch reported by execute
    typedef struct packed {
        logic                 valid;
        logic [addrWidth-1:0] addr;
        logic [addrWidth-1:0] target;
        logic                 taken;
    } predUpdate_t;

    // Lookup result for the current PC
    typedef struct packed {
        logic                 taken;
        logic [addrWidth-1:0] target;
        counter_t             counter;
    } prediction_t;

endpackage

// ==== hdl/pipeReg.sv ====
`timescale 1ns/100ps

module pipeReg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     Clk,
    input  logic     reset,
    input  logic     stall,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    // All-zero payload is a bubble, valid bit included
    always_ff @(posedge Clk) begin
        if (reset) begin
            q <= '0;
        end else if (stall) begin
            q <= q;
        end else if (flush) begin
            q <= '0;
        end else begin
            q <= d;
        end
    end

    // Parent has to clear stall on a flush, otherwise the flush is lost
    assert property (@(posedge Clk) disable iff (reset)
        !(stall && flush));

endmodule

// ==== hdl/instrMemPort.sv ====
`timescale 1ns/100ps

module instrMemPort
    import fetchPkg::*;
(
    input  logic                 Clk,
    input  logic                 reset,
    input  logic [addrWidth-1:0] pc,
    input  logic                 stall,
    input  logic                 flush,
    input  imemResp_t            imemResp,
    output logic [addrWidth-1:0] imemAddr,
    output logic                 imemReq,
    output logic                 instrMiss,
    output fetched_t             fetched
);

    logic                 missPending;
    logic [addrWidth-1:0] missAddr;

    // No request in reset, while frozen or while the PC is being redirected
    assign imemReq   = !reset && !stall && !flush;
    assign imemAddr  = missPending ? missAddr : pc;
    assign instrMiss = imemReq && !imemResp.hit;

    always_comb begin
        fetched.valid = imemReq && imemResp.hit;
        fetched.addr  = imemAddr;
        fetched.instr = imemResp.instr;
    end

    // Remember an outstanding miss until it hits or gets flushed
    always_ff @(posedge Clk) begin
        if (reset || flush) begin
            missPending <= 1'b0;
        end else if (imemReq) begin
            missPending <= !imemResp.hit;
        end
    end

    always_ff @(posedge Clk) begin
        if (instrMiss) begin
            missAddr <= imemAddr;
        end
    end

    // Cache model must give a defined hit whenever it is asked
    assert property (@(posedge Clk) disable iff (reset)
        imemReq |-> !$isunknown(imemResp.hit));

    // Fetch control is expected to hold the PC on the missed address
    assert property (@(posedge Clk) disable iff (reset)
        missPending && !flush |-> missAddr == pc);

endmodule

// ==== hdl/branchPredictor.sv ====
`timescale 1ns/100ps

module branchPredictor
    import fetchPkg::*;
    import predictPkg::*;
(
    input  logic                 Clk,
    input  logic                 reset,
    input  logic [addrWidth-1:0] pc,
    input  predUpdate_t          update,
    output prediction_t          prediction
);

    logic [tagWidth-1:0]       tagTable     [predEntries];
    logic [addrWidth-1:0]      targetTable  [predEntries];
    counter_t                  counterTable [predEntries];
    logic [predEntries-1:0]    entryValid;

    logic [predIndexWidth-1:0] lookupIndex;
    logic [tagWidth-1:0]       lookupTag;
    logic                      lookupHit;
    logic [predIndexWidth-1:0] updIndex;
    logic [tagWidth-1:0]       updTag;
    logic                      sameBranch;
    counter_t                  baseCount;

    // One step toward the outcome, saturating at both ends
    function automatic counter_t stepCounter(input counter_t count, input logic taken);
        counter_t result;
        case (count)
            strongNotTaken: result = taken ? weakNotTaken : strongNotTaken;
            weakNotTaken:   result = taken ? weakTaken    : strongNotTaken;
            weakTaken:      result = taken ? strongTaken  : weakNotTaken;
            default:        result = taken ? strongTaken  : weakTaken;
        endcase
        return result;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Lookup
    ////////////////////////////////////////////////////////////////////////////
    assign lookupIndex = pc[predIndexWidth+1:2];
    assign lookupTag   = pc[addrWidth-1:predIndexWidth+2];
    assign lookupHit   = entryValid[lookupIndex] && (tagTable[lookupIndex] == lookupTag);

    always_comb begin
        prediction.counter = lookupHit ? counterTable[lookupIndex] : weakNotTaken;
        prediction.taken   = lookupHit && prediction.counter[1];
        prediction.target  = targetTable[lookupIndex];
    end

    ////////////////////////////////////////////////////////////////////////////
    // Update
    ////////////////////////////////////////////////////////////////////////////
    assign updIndex   = update.addr[predIndexWidth+1:2];
    assign updTag     = update.addr[addrWidth-1:predIndexWidth+2];
    assign sameBranch = entryValid[updIndex] && (tagTable[updIndex] == updTag);
    // A new branch in this slot starts again from weakly not-taken
    assign baseCount  = sameBranch ? counterTable[updIndex] : weakNotTaken;

    always_ff @(posedge Clk) begin
        if (reset) begin
            entryValid <= '0;
        end else if (update.valid) begin
            entryValid[updIndex] <= 1'b1;
        end
    end

    always_ff @(posedge Clk) begin
        if (update.valid) begin
            tagTable[updIndex]     <= updTag;
            targetTable[updIndex]  <= update.target;
            counterTable[updIndex] <= stepCounter(baseCount, update.taken);
        end
    end

    assert property (@(posedge Clk) disable iff (reset)
        update.valid |-> update.addr[1:0] == 2'b00);

endmodule

// ==== hdl/fetchControl.sv ====
`timescale 1ns/100ps

module fetchControl
    import fetchPkg::*;
    import predictPkg::*;
(
    input  logic                 Clk,
    input  logic                 reset,
    input  redirect_t            redirect,
    input  logic                 stall,
    input  logic                 instrMiss,
    input  prediction_t          prediction,
    output logic [addrWidth-1:0] pc,
    output logic [addrWidth-1:0] predictedNext
);

    logic [addrWidth-1:0] seqNext;
    logic                 holdPc;
    logic [addrWidth-1:0] nextPc;

    ////////////////////////////////////////////////////////////////////////////
    // Next address selection
    ////////////////////////////////////////////////////////////////////////////
    assign seqNext = pc + addrWidth'(4);

    // Address the current instruction is expected to be followed by
    assign predictedNext = prediction.taken ? prediction.target : seqNext;

    // Back-pressure and misses both keep the current address
    assign holdPc = stall || instrMiss;

    always_comb begin
        if (redirect.valid) begin
            nextPc = redirect.target;
        end else if (holdPc) begin
            nextPc = pc;
        end else begin
            nextPc = predictedNext;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // PC register
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge Clk) begin
        if (reset) begin
            pc <= resetPc;
        end else begin
            pc <= nextPc;
        end
    end

    // Redirect and stored targets must both keep fetch word-aligned
    assert property (@(posedge Clk) disable iff (reset)
        pc[1:0] == 2'b00);

endmodule

// ==== hdl/fetchStage.sv ====
`timescale 1ns/100ps

module fetchStage
    import fetchPkg::*;
    import predictPkg::*;
(
    input  logic                 Clk,
    input  logic                 reset,
    input  redirect_t            redirect,
    input  predUpdate_t          update,
    input  logic                 stall,
    input  imemResp_t            imemResp,
    output logic [addrWidth-1:0] imemAddr,
    output logic                 imemReq,
    output logic                 instrMiss,
    output ifIdEntry_t           ifId
);

    logic [addrWidth-1:0] pc;
    logic [addrWidth-1:0] predictedNext;
    fetched_t             fetched;
    prediction_t          prediction;
    predUpdate_t          updateReg;
    ifIdEntry_t           ifIdNext;

    ////////////////////////////////////////////////////////////////////////////
    // Input side
    ////////////////////////////////////////////////////////////////////////////
    instrMemPort instrMemPort_inst (
        .Clk       (Clk),
        .reset     (reset),
        .pc        (pc),
        .stall     (stall),
        .flush     (redirect.valid),
        .imemResp  (imemResp),
        .imemAddr  (imemAddr),
        .imemReq   (imemReq),
        .instrMiss (instrMiss),
        .fetched   (fetched)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Fetch control and prediction
    ////////////////////////////////////////////////////////////////////////////
    fetchControl fetchControl_inst (
        .Clk           (Clk),
        .reset         (reset),
        .redirect      (redirect),
        .stall         (stall),
        .instrMiss     (instrMiss),
        .prediction    (prediction),
        .pc            (pc),
        .predictedNext (predictedNext)
    );

    // Update is registered once before it reaches the table
    pipeReg #(.payload_t(predUpdate_t)) updateReg_inst (
        .Clk   (Clk),
        .reset (reset),
        .stall (1'b0),
        .flush (1'b0),
        .d     (update),
        .q     (updateReg)
    );

    branchPredictor branchPredictor_inst (
        .Clk        (Clk),
        .reset      (reset),
        .pc         (pc),
        .update     (updateReg),
        .prediction (prediction)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Output side
    ////////////////////////////////////////////////////////////////////////////
    assign ifIdNext = '{
        valid:         fetched.valid,
        addr:          fetched.addr,
        instr:         fetched.instr,
        predictedNext: predictedNext,
        predTaken:     prediction.taken,
        counter:       prediction.counter
    };

    // Redirect beats stall, a miss only bubbles when not stalled
    pipeReg #(.payload_t(ifIdEntry_t)) ifIdReg_inst (
        .Clk   (Clk),
        .reset (reset),
        .stall (stall && !redirect.valid),
        .flush (redirect.valid || instrMiss),
        .d     (ifIdNext),
        .q     (ifId)
    );

endmodule

// ==== verification/fetchStageTb.sv ====
`timescale 1ns/100ps

module fetchStageTb
    import fetchPkg::*;
    import predictPkg::*;
();

    localparam logic [31:0] memPattern  = 32'hA5A5_0000;
    localparam int          resetCycles = 16;
    localparam int          maxCycles   = 2000;
    localparam int          maxLines    = 200;
    localparam int          hitTimeout  = 8;

    logic                 Clk = 1'b0;
    logic                 reset;
    redirect_t            redirect;
    predUpdate_t          update;
    logic                 stall;
    imemResp_t            imemResp;
    logic [addrWidth-1:0] imemAddr;
    logic                 imemReq;
    logic                 instrMiss;
    ifIdEntry_t           ifId;

    logic forceMiss;
    logic runDone = 1'b0;
    int   seed;
    int   valueErrors;
    int   otherErrors;
    int   caseCount;

    fetchStage fetchStage_inst (
        .Clk       (Clk),
        .reset     (reset),
        .redirect  (redirect),
        .update    (update),
        .stall     (stall),
        .imemResp  (imemResp),
        .imemAddr  (imemAddr),
        .imemReq   (imemReq),
        .instrMiss (instrMiss),
        .ifId      (ifId)
    );

    always #2 Clk = ~Clk;

    // Instruction cache model with the word derived from the address
    always_comb begin
        imemResp.hit   = !forceMiss;
        imemResp.instr = imemAddr ^ memPattern;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////
    task automatic reportMismatch(input string what, input logic [31:0] got,
                                  input logic [31:0] want);
        valueErrors++;
        $display("ERR %0t: %s is %h, expected %h", $time, what, got, want);
    endtask

    task automatic reportFailure(input string what);
        otherErrors++;
        $display("%s", what);
    endtask

    // Next edge and then idle inputs a little after it
    task automatic beginCycle();
        @(posedge Clk);
        #0.5;
        redirect  = '0;
        update    = '0;
        stall     = 1'b0;
        forceMiss = 1'b0;
    endtask

    task automatic settle();
        #1;
    endtask

    task automatic checkInstr();
        if (ifId.valid && ifId.instr !== (ifId.addr ^ memPattern)) begin
            reportMismatch("ifId.instr", ifId.instr, ifId.addr ^ memPattern);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Case operations
    ////////////////////////////////////////////////////////////////////////////
    task automatic runIdle(input int cycles, input logic [31:0] expAddr);
        logic        prevValid;
        logic [31:0] prevNext;
        prevValid = 1'b0;
        prevNext  = '0;
        for (int i = 0; i < cycles; i++) begin
            beginCycle();
            settle();
            checkInstr();
            if (ifId.valid && !ifId.predTaken && ifId.predictedNext !== ifId.addr + 32'd4) begin
                reportMismatch("ifId.predictedNext", ifId.predictedNext, ifId.addr + 32'd4);
            end
            // Sequential entries rise by one word
            if (ifId.valid && prevValid && ifId.addr !== prevNext) begin
                reportMismatch("ifId.addr", ifId.addr, prevNext);
            end
            prevValid = ifId.valid && !ifId.predTaken;
            prevNext  = ifId.addr + 32'd4;
        end
        if (imemAddr !== expAddr) begin
            reportMismatch("imemAddr after run", imemAddr, expAddr);
        end
    endtask

    task automatic applyRedirect(input logic [31:0] newTarget, input logic [31:0] expNext);
        logic expTaken;
        // Any next address other than the sequential one means a taken prediction
        expTaken = (expNext !== newTarget + 32'd4);
        beginCycle();
        redirect = '{valid: 1'b1, target: newTarget};
        settle();
        if (imemReq !== 1'b0) begin
            reportMismatch("imemReq during redirect", 32'(imemReq), 32'd0);
        end
        beginCycle();
        settle();
        if (ifId.valid !== 1'b0) begin
            reportMismatch("ifId.valid after redirect", 32'(ifId.valid), 32'd0);
        end
        if (imemAddr !== newTarget) begin
            reportMismatch("imemAddr after redirect", imemAddr, newTarget);
        end
        beginCycle();
        settle();
        checkInstr();
        if (ifId.valid !== 1'b1) begin
            reportMismatch("ifId.valid at target", 32'(ifId.valid), 32'd1);
        end
        if (ifId.addr !== newTarget) begin
            reportMismatch("ifId.addr at target", ifId.addr, newTarget);
        end
        if (ifId.predictedNext !== expNext) begin
            reportMismatch("ifId.predictedNext at target", ifId.predictedNext, expNext);
        end
        if (ifId.predTaken !== expTaken) begin
            reportMismatch("ifId.predTaken at target", 32'(ifId.predTaken), 32'(expTaken));
        end
        // Both taken states have the msb set
        if (ifId.counter[1] !== expTaken) begin
            reportMismatch("ifId.counter msb at target", 32'(ifId.counter[1]),
                           32'(expTaken));
        end
        if (imemAddr !== expNext) begin
            reportMismatch("imemAddr after target", imemAddr, expNext);
        end
    endtask

    task automatic applyUpdate(input logic [31:0] branchAddr, input logic [31:0] branchTarget,
                               input logic taken);
        beginCycle();
        update = '{valid: 1'b1, addr: branchAddr, target: branchTarget, taken: taken};
        settle();
        checkInstr();
    endtask

    task automatic holdStall(input int cycles, input logic [31:0] expAddr);
        logic [31:0] frozenAddr;
        ifIdEntry_t  frozenIfId;
        int          stallLen;
        frozenAddr = '0;
        frozenIfId = '0;
        stallLen   = cycles;
        // Zero length asks for a random gap of 1 to 4 cycles
        if (stallLen == 0) begin
            stallLen = 1 + int'($unsigned($random(seed)) % 32'd4);
        end
        for (int i = 0; i < stallLen; i++) begin
            beginCycle();
            stall = 1'b1;
            settle();
            if (i == 0) begin
                frozenAddr = imemAddr;
                frozenIfId = ifId;
            end
            if (imemReq !== 1'b0) begin
                reportMismatch("imemReq during stall", 32'(imemReq), 32'd0);
            end
            if (imemAddr !== frozenAddr) begin
                reportMismatch("imemAddr during stall", imemAddr, frozenAddr);
            end
            if (ifId !== frozenIfId) begin
                reportMismatch("ifId.addr during stall", ifId.addr, frozenIfId.addr);
            end
        end
        beginCycle();
        settle();
        if (imemAddr !== expAddr) begin
            reportMismatch("imemAddr after stall", imemAddr, expAddr);
        end
        if (ifId !== frozenIfId) begin
            reportMismatch("ifId.addr after stall", ifId.addr, frozenIfId.addr);
        end
    endtask

    task automatic forceMisses(input int cycles, input logic [31:0] expAddr);
        logic [31:0] heldAddr;
        logic        gotValid;
        heldAddr = '0;
        gotValid = 1'b0;
        for (int i = 0; i < cycles; i++) begin
            beginCycle();
            forceMiss = 1'b1;
            settle();
            if (i == 0) begin
                heldAddr = imemAddr;
            end
            if (instrMiss !== 1'b1) begin
                reportMismatch("instrMiss", 32'(instrMiss), 32'd1);
            end
            if (imemAddr !== heldAddr) begin
                reportMismatch("imemAddr during miss", imemAddr, heldAddr);
            end
            if (i > 0 && ifId.valid !== 1'b0) begin
                reportMismatch("ifId.valid during miss", 32'(ifId.valid), 32'd0);
            end
        end
        if (heldAddr !== expAddr) begin
            reportMismatch("missed address", heldAddr, expAddr);
        end
        // Memory hits again so wait for the refetched word
        for (int i = 0; i < hitTimeout && !gotValid; i++) begin
            beginCycle();
            settle();
            if (i == 0 && imemAddr !== heldAddr) begin
                reportMismatch("imemAddr on refetch", imemAddr, heldAddr);
            end
            if (ifId.valid) begin
                gotValid = 1'b1;
                checkInstr();
                if (ifId.addr !== heldAddr) begin
                    reportMismatch("ifId.addr after miss", ifId.addr, heldAddr);
                end
            end
        end
        if (!gotValid) begin
            reportFailure("Timeout: no valid instruction arrived after the miss cleared");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        string       line;
        string       opName;
        int          fd;
        int          n;
        logic [31:0] arg1;
        logic [31:0] arg2;
        logic [31:0] arg3;
        logic [31:0] expAddr;
        reset       = 1'b1;
        redirect    = '0;
        update      = '0;
        stall       = 1'b0;
        forceMiss   = 1'b1;
        seed        = 15;
        valueErrors = 0;
        otherErrors = 0;
        caseCount   = 0;

        repeat (resetCycles) @(posedge Clk);
        #0.5;
        // Still in reset while the memory reports a miss
        if (imemReq !== 1'b0) begin
            reportMismatch("imemReq in reset", 32'(imemReq), 32'd0);
        end
        if (instrMiss !== 1'b0) begin
            reportMismatch("instrMiss in reset", 32'(instrMiss), 32'd0);
        end
        if (ifId.valid !== 1'b0) begin
            reportMismatch("ifId.valid in reset", 32'(ifId.valid), 32'd0);
        end
        reset     = 1'b0;
        forceMiss = 1'b0;
        settle();
        if (ifId.valid !== 1'b0) begin
            reportMismatch("ifId.valid after reset", 32'(ifId.valid), 32'd0);
        end
        if (instrMiss !== 1'b0) begin
            reportMismatch("instrMiss after reset", 32'(instrMiss), 32'd0);
        end
        if (imemAddr !== resetPc) begin
            reportMismatch("first fetch address", imemAddr, resetPc);
        end

        fd = $fopen("verification/fetchCases.txt", "r");
        if (fd == 0) begin
            reportFailure("Could not open the case file verification/fetchCases.txt");
        end else begin
            for (int lineNo = 0; lineNo < maxLines && !$feof(fd); lineNo++) begin
                n = $fgets(line, fd);
                if (n > 0) begin
                    n = $sscanf(line, "%s %h %h %h %h", opName, arg1, arg2, arg3, expAddr);
                    // Blank lines and comment lines carry no case
                    if (n > 0 && opName.substr(0, 0) != "#") begin
                        caseCount++;
                        if (n != 5) begin
                            reportFailure({"Malformed case line: ", line});
                        end else if (opName == "run") begin
                            runIdle(int'(arg1), expAddr);
                        end else if (opName == "redirect") begin
                            applyRedirect(arg1, expAddr);
                        end else if (opName == "update") begin
                            applyUpdate(arg1, arg2, arg3[0]);
                        end else if (opName == "stall") begin
                            holdStall(int'(arg1), expAddr);
                        end else if (opName == "miss") begin
                            forceMisses(int'(arg1), expAddr);
                        end else begin
                            reportFailure({"Unknown operation in case file: ", opName});
                        end
                    end
                end
            end
            $fclose(fd);
            if (caseCount == 0) begin
                reportFailure("No cases were read from the case file");
            end
        end

        runDone = 1'b1;
        $display("Done: %0d cases, %0d value errors, %0d other errors",
                 caseCount, valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // Watchdog on the whole run
    initial begin
        int cycle;
        for (cycle = 0; cycle < maxCycles && !runDone; cycle++) begin
            @(posedge Clk);
        end
        if (!runDone) begin
            $display("Timeout: the run did not finish within %0d cycles", maxCycles);
            $display("Some tests failed");
            $finish;
        end
    end

endmodule

// ==== project.f ====
hdl/fetchPkg.sv
hdl/predictPkg.sv
hdl/pipeReg.sv
hdl/instrMemPort.sv
hdl/branchPredictor.sv
hdl/fetchControl.sv
hdl/fetchStage.sv
verification/fetchStageTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= fetchStageTb
RTL_TOP   ?= fetchStage
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== verification/fetchCases.txt ====
# op       arg1     arg2     arg3 expected
# run: cycles, redirect: target, update: branch target taken, stall: cycles (0 is random)
# expected is imemAddr at the end of the case, the next fetch after a redirect target,
# the resume address after a stall, or the held address of a miss
run        00000008 00000000 0    00000020
redirect   00000040 00000000 0    00000044
run        00000004 00000000 0    00000054
stall      00000003 00000000 0    00000058
run        00000002 00000000 0    00000060
miss       00000002 00000000 0    00000064
run        00000003 00000000 0    00000074
update     00000100 00000200 1    00000000
update     00000100 00000200 1    00000000
redirect   00000100 00000000 0    00000200
run        00000002 00000000 0    00000208
update     00000100 00000200 0    00000000
update     00000100 00000200 0    00000000
run        00000001 00000000 0    00000214
redirect   00000100 00000000 0    00000104
stall      00000000 00000000 0    00000108
redirect   00000300 00000000 0    00000304
miss       00000001 00000000 0    00000308
run        00000004 00000000 0    0000031c
